/* design/conv_defines.svh */
/*
 conv row shifter sizes
 pixel width, window width and kernel limits shared by every block
*/
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// bits per pixel word
`define DATA_WIDTH 16

// words per output window
`define CONV_UNITS 8

// tallest kernel the shifter handles
`define KERNEL_H_MAX 3

// channel count width
`define CH_IN_COUNTER_WIDTH 10

// padded row width, one extra word per extra kernel row
`define IN_WORDS (`CONV_UNITS + `KERNEL_H_MAX - 1)

`endif

/* design/conv_types_pkg.sv */
/*
 convolution types
 pixel word, kernel height code, channel count and shift number
*/
`include "conv_defines.svh"

package conv_types_pkg;

    // one pixel
    typedef logic [`DATA_WIDTH-1:0] pixel_t;

    // kernel height minus one
    // kept KERNEL_H_MAX wide like the config bus upstream
    typedef logic [`KERNEL_H_MAX-1:0] kernel_h_t;

    // input channels minus one, also the channel counter value
    typedef logic [`CH_IN_COUNTER_WIDTH-1:0] ch_count_t;

    // shift number within a row
    typedef logic [$clog2(`KERNEL_H_MAX)-1:0] shift_idx_t;

endpackage

/* design/axis_stream_pkg.sv */
/*
 stream beat types
 padded row beat with its config, output window beat, skid states
*/
`include "conv_defines.svh"

package axis_stream_pkg;

    import conv_types_pkg::*;

    // one padded row with the config it must be processed with
    typedef struct packed {
        pixel_t [`IN_WORDS-1:0] words;   // word 0 is the top of the window
        kernel_h_t              kernel_h_1;
        ch_count_t              ch_in_1;
    } row_beat_t;

    // one shifted window
    typedef struct packed {
        pixel_t [`CONV_UNITS-1:0] words;
        logic                     last;  // end of channel group
    } win_beat_t;

    // skid occupancy
    typedef enum logic [1:0] {
        skid_empty,
        skid_one,
        skid_full
    } skid_state_t;

endpackage

/* design/skid_buffer.sv */
/*
 skid buffer for padded rows
 two-entry stage with a registered s_ready toward the source
*/
`timescale 1ns/10ps

module skid_buffer (
    input  logic                       aclk,
    input  logic                       reset,
    input  axis_stream_pkg::row_beat_t s_row,
    input  logic                       s_valid,
    output logic                       s_ready,
    output axis_stream_pkg::row_beat_t q_row,
    output logic                       q_valid,
    input  logic                       q_ready
);
    import axis_stream_pkg::*;

    skid_state_t state;
    skid_state_t state_next;
    row_beat_t   spare_row;  // beat caught when q side stalls
    logic        s_xfer;
    logic        q_xfer;

    assign s_xfer  = s_valid && s_ready;
    assign q_xfer  = q_valid && q_ready;
    assign q_valid = (state != skid_empty);  // output reg holds a beat

    always_comb begin
        state_next = state;
        case (state)
            skid_empty: begin
                if (s_xfer) state_next = skid_one;
            end
            skid_one: begin
                if (s_xfer && !q_xfer) state_next = skid_full;      // spare takes it
                else if (!s_xfer && q_xfer) state_next = skid_empty;
            end
            skid_full: begin
                if (q_xfer) state_next = skid_one;  // spare moves up
            end
            default: state_next = skid_empty;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state   <= skid_empty;
            s_ready <= 1'b0;
        end else begin
            state   <= state_next;
            s_ready <= (state_next != skid_full);  // drops only with both entries used
        end
    end

    // payload moves
    always_ff @(posedge aclk) begin
        case (state)
            skid_empty: begin
                if (s_xfer) q_row <= s_row;
            end
            skid_one: begin
                if (s_xfer && q_xfer) q_row <= s_row;  // pass through
                else if (s_xfer) spare_row <= s_row;
            end
            skid_full: begin
                if (q_xfer) q_row <= spare_row;
            end
            default: ;
        endcase
    end

endmodule

/* design/beat_last_gen.sv */
/*
 tlast generator
 counts rows per channel group and marks the final shift of the last row
*/
`timescale 1ns/10ps

module beat_last_gen (
    input  logic                       aclk,
    input  logic                       reset,
    input  logic                       win_xfer,    // window register takes a new window
    input  conv_types_pkg::shift_idx_t shift_idx,   // shift number of that window
    input  conv_types_pkg::kernel_h_t  kernel_h_1,  // config of its row
    input  conv_types_pkg::ch_count_t  ch_in_1,
    output logic                       last
);
    import conv_types_pkg::*;

    ch_count_t count;        // position of the next row in its group
    logic      row_load;
    logic      grp_end;      // row in the window register closes the group
    logic      grp_end_now;
    logic      final_shift;

    // shift 0 only ever enters on a row load
    assign row_load = win_xfer && (shift_idx == '0);

    // a new row decides group end from the counter, later shifts reuse the flag
    assign grp_end_now = row_load ? (count == ch_in_1) : grp_end;

    assign final_shift = (kernel_h_t'(shift_idx) == kernel_h_1);

    always_ff @(posedge aclk) begin
        if (reset) begin
            count   <= '0;
            grp_end <= 1'b0;
            last    <= 1'b0;
        end else if (win_xfer) begin
            // loaded with the window so it stays with its data beat
            last <= grp_end_now && final_shift;
            if (row_load) begin
                grp_end <= grp_end_now;
                if (count == ch_in_1) begin
                    count <= '0;  // group complete
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

/* design/axis_shift_buffer.sv */
/*
 row shifter
 loads a padded row and releases kernel_h windows, each one word further down
*/
`timescale 1ns/10ps

`include "conv_defines.svh"

module axis_shift_buffer (
    input  logic                       aclk,
    input  logic                       reset,
    input  axis_stream_pkg::row_beat_t q_row,
    input  logic                       q_valid,
    output logic                       q_ready,
    output axis_stream_pkg::win_beat_t m_win,
    output logic                       m_valid,
    input  logic                       m_ready
);
    import conv_types_pkg::*;

    pixel_t [`IN_WORDS-1:0] win_q;  // row being shifted, low words go out

    /*
     idx names the shift entering the window register next
     idx 0 with m_valid high means the final shift is on m_win
    */
    shift_idx_t idx;
    shift_idx_t idx_next;
    shift_idx_t shift_sel;
    kernel_h_t  kh_q;    // height of the row in flight
    kernel_h_t  kh_sel;
    ch_count_t  ch_q;
    ch_count_t  ch_sel;
    logic       load;    // new row into the window register
    logic       remove;  // output transfer
    logic       step;    // shift down one word
    logic       win_xfer;
    logic       last;

    // next row only once the previous row's final shift leaves
    assign q_ready  = (idx == '0) && m_ready;
    assign load     = q_valid && q_ready;
    assign remove   = m_valid && m_ready;
    assign step     = remove && (idx != '0);
    assign win_xfer = load || step;

    always_comb begin
        idx_next = idx;
        if (load) begin
            // a one-row kernel is done after shift 0
            idx_next = (q_row.kernel_h_1 == '0) ? '0 : shift_idx_t'(1);
        end else if (step) begin
            if (kernel_h_t'(idx) == kh_q) begin
                idx_next = '0;  // final shift going in
            end else begin
                idx_next = idx + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            idx     <= '0;
            m_valid <= 1'b0;
            kh_q    <= '0;
            ch_q    <= '0;
        end else begin
            idx <= idx_next;
            // valid follows the skid side between rows, holds mid-row and on stall
            if ((idx == '0) && m_ready) begin
                m_valid <= q_valid;
            end
            if (load) begin
                kh_q <= q_row.kernel_h_1;
                ch_q <= q_row.ch_in_1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            win_q <= q_row.words;
        end else if (step) begin
            for (int i = 0; i < `IN_WORDS - 1; i++) begin
                win_q[i] <= win_q[i+1];  // move down from upper neighbour
            end
            // top word holds
        end
    end

    // config of the row whose window enters now
    assign shift_sel = load ? '0 : idx;
    assign kh_sel    = load ? q_row.kernel_h_1 : kh_q;
    assign ch_sel    = load ? q_row.ch_in_1 : ch_q;

    beat_last_gen beat_last_gen_inst (
        .aclk       (aclk),
        .reset      (reset),
        .win_xfer   (win_xfer),
        .shift_idx  (shift_sel),
        .kernel_h_1 (kh_sel),
        .ch_in_1    (ch_sel),
        .last       (last)
    );

    assign m_win.words = win_q[`CONV_UNITS-1:0];
    assign m_win.last  = last;

endmodule

/* design/shift_buffer_top.sv */
/*
 row shifter top
 skid buffer in front of the shift buffer
*/
`timescale 1ns/10ps

module shift_buffer_top (
    input  logic                       aclk,
    input  logic                       reset,

    // padded rows in
    input  axis_stream_pkg::row_beat_t s_row,
    input  logic                       s_valid,
    output logic                       s_ready,

    // shifted windows out
    output axis_stream_pkg::win_beat_t m_win,
    output logic                       m_valid,
    input  logic                       m_ready
);
    import axis_stream_pkg::*;

    row_beat_t q_row;    // skid output row
    logic      q_valid;
    logic      q_ready;  // only between rows

    skid_buffer skid_buffer_inst (
        .aclk    (aclk),
        .reset   (reset),
        .s_row   (s_row),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .q_row   (q_row),
        .q_valid (q_valid),
        .q_ready (q_ready)
    );

    axis_shift_buffer axis_shift_buffer_inst (
        .aclk    (aclk),
        .reset   (reset),
        .q_row   (q_row),
        .q_valid (q_valid),
        .q_ready (q_ready),
        .m_win   (m_win),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

/* dv/shift_buffer_assertions.sv */
/*
 stream protocol assertions
 hold rules on the internal and output streams and a quiet output in reset
*/
`timescale 1ns/10ps

module shift_buffer_assertions (
    input logic                       aclk,
    input logic                       reset,
    input axis_stream_pkg::row_beat_t q_row,
    input logic                       q_valid,
    input logic                       q_ready,
    input axis_stream_pkg::win_beat_t m_win,
    input logic                       m_valid,
    input logic                       m_ready
);
    int fail_count = 0;  // assertion failures so far

    // window and valid frozen while the sink stalls
    m_hold: assert property (@(posedge aclk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_win))
        else begin
            $error("m_win changed or m_valid dropped during a stall");
            fail_count++;
        end

    // skid output holds while the shifter drains a row
    q_hold: assert property (@(posedge aclk) disable iff (reset)
        q_valid && !q_ready |=> q_valid && $stable(q_row))
        else begin
            $error("q_row changed or q_valid dropped during a stall");
            fail_count++;
        end

    m_quiet: assert property (@(posedge aclk) reset |=> !m_valid)
        else begin
            $error("m_valid high after a reset cycle");
            fail_count++;
        end

endmodule

bind shift_buffer_top shift_buffer_assertions shift_buffer_assertions_inst (
    .aclk    (aclk),
    .reset   (reset),
    .q_row   (q_row),
    .q_valid (q_valid),
    .q_ready (q_ready),
    .m_win   (m_win),
    .m_valid (m_valid),
    .m_ready (m_ready)
);

/* dv/shift_buffer_tb.sv */
/*
 row shifter testbench
 LFSR rows and stalls against a window model with per-test lines and a summary
*/
`timescale 1ns/10ps

`include "conv_defines.svh"

module shift_buffer_tb;
    import conv_types_pkg::*;
    import axis_stream_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int ROWS_PER_TEST = 24;
    localparam int MAX_STALL     = 4;   // longest m_ready low run in cycles
    localparam int MAX_GAP       = 3;   // longest s_valid low run in cycles
    localparam int KH_3          = 0;
    localparam int KH_1          = 1;
    localparam int KH_MIX        = 2;
    localparam int CH_CYCLE      = 0;   // groups of 1, 2, 3, 4 rows in turn
    localparam int CH_RAND       = 1;
    // whole groups let each of the six tests overshoot by three rows
    localparam int MAX_WINDOWS   = 6 * (ROWS_PER_TEST + 3) * `KERNEL_H_MAX;
    localparam int WATCHDOG_CYC  = MAX_WINDOWS * (MAX_STALL + MAX_GAP + 2) + 100;

    logic        aclk;
    logic        reset;
    row_beat_t   s_row;
    logic        s_valid;
    logic        s_ready;
    win_beat_t   m_win;
    logic        m_valid;
    logic        m_ready;

    logic [15:0] lfsr_state;
    win_beat_t   exp_q[$];     // windows owed by accepted rows
    ch_count_t   model_ch;     // group size of the current group
    int          model_pos;    // row position within the group
    int          checks;
    int          errors;

    shift_buffer_top shift_buffer_top_inst (
        .aclk    (aclk),
        .reset   (reset),
        .s_row   (s_row),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_win   (m_win),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 16'hB400;
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // expand one accepted row into its windows
    task automatic model_accept(input row_beat_t row);
        win_beat_t w;
        logic      grp_end;
        if (row.ch_in_1 != model_ch) begin
            model_ch  = row.ch_in_1;  // new group size restarts the count
            model_pos = 0;
        end
        grp_end   = (model_pos == int'(row.ch_in_1));
        model_pos = grp_end ? 0 : model_pos + 1;
        for (int s = 0; s <= int'(row.kernel_h_1); s++) begin
            for (int j = 0; j < `CONV_UNITS; j++) begin
                w.words[j] = row.words[s + j];  // shift s starts at word s
            end
            w.last = grp_end && (s == int'(row.kernel_h_1));
            exp_q.push_back(w);
        end
    endtask

    task automatic run_rows(input int num, input string name, input int n_rows,
                            input int kh_mode, input int ch_mode, input bit stalls,
                            input bit gaps);
        row_beat_t rows[$];
        row_beat_t row;
        win_beat_t exp_win;
        int        grp;
        int        ch;
        int        total;
        int        sent;
        int        got;
        int        stall_left;
        int        gap_left;
        int        err_start;
        bit        presenting;
        bit        accepted;
        err_start = errors;
        grp       = 0;
        total     = 0;
        while (rows.size() < n_rows) begin  // whole groups only
            ch = (ch_mode == CH_CYCLE) ? grp % 4 : int'(rand_bits(2));
            for (int r = 0; r <= ch; r++) begin
                for (int w = 0; w < `IN_WORDS; w++) begin
                    row.words[w] = pixel_t'(rand_bits(`DATA_WIDTH));
                end
                case (kh_mode)
                    KH_3:    row.kernel_h_1 = kernel_h_t'(2);
                    KH_1:    row.kernel_h_1 = kernel_h_t'(0);
                    default: row.kernel_h_1 = (rand_bits(1) != 0) ? kernel_h_t'(2) : '0;
                endcase
                row.ch_in_1 = ch_count_t'(ch);
                rows.push_back(row);
                total += int'(row.kernel_h_1) + 1;
            end
            grp++;
        end
        sent       = 0;
        got        = 0;
        stall_left = 0;
        gap_left   = 0;
        presenting = 1'b0;
        accepted   = 1'b0;
        while (got < total) begin
            @(posedge aclk);
            if (accepted) begin
                sent++;
                presenting = 1'b0;
                if (gaps) gap_left = int'(rand_bits(2));
            end
            if (!presenting && sent < rows.size()) begin
                if (gap_left > 0) gap_left--;
                else presenting = 1'b1;
            end
            s_valid <= presenting;
            if (presenting) s_row <= rows[sent];  // held until taken
            if (stall_left > 0) begin
                m_ready <= 1'b0;
                stall_left--;
            end else begin
                m_ready <= 1'b1;  // one ready cycle before any stall
                if (stalls && rand_bits(2) == 0) stall_left = int'(rand_bits(2)) + 1;
            end
            accepted = 1'b0;
            @(negedge aclk);
            if (s_valid && s_ready) begin  // transfer on the coming edge
                accepted = 1'b1;
                model_accept(rows[sent]);
            end
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("window at %0t with no accepted row to match it", $time);
                end else begin
                    exp_win = exp_q.pop_front();
                    check_value("m_win.words", m_win.words, exp_win.words);
                    check_value("m_win.last", m_win.last, exp_win.last);
                end
                got++;
            end
        end
        @(posedge aclk);
        s_valid <= 1'b0;
        m_ready <= 1'b1;
        repeat (4) begin  // extra or duplicated windows would show here
            @(negedge aclk);
            check_value("m_valid", m_valid, 1'b0);
        end
        $display("test %0d %s: %0d rows, %0d windows, %0d errors", num, name,
                 rows.size(), total, errors - err_start);
    endtask

    task automatic reset_test();
        row_beat_t row;
        for (int w = 0; w < `IN_WORDS; w++) begin
            row.words[w] = pixel_t'(rand_bits(`DATA_WIDTH));
        end
        row.kernel_h_1 = kernel_h_t'(2);
        row.ch_in_1    = '0;
        // window on m_win and rows in the skid when reset hits
        @(posedge aclk);
        s_row   <= row;
        s_valid <= 1'b1;
        m_ready <= 1'b1;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        check_value("m_valid", m_valid, 1'b1);  // window pending
        @(posedge aclk);
        reset   <= 1'b1;
        s_valid <= 1'b0;
        m_ready <= 1'b0;
        repeat (9) begin
            @(posedge aclk);
            @(negedge aclk);
            check_value("m_valid", m_valid, 1'b0);
            check_value("s_ready", s_ready, 1'b0);
        end
        @(posedge aclk);
        reset   <= 1'b0;
        m_ready <= 1'b1;  // a stale skid row would load from here on
        exp_q.delete();
        model_ch  = '0;
        model_pos = 0;
        @(posedge aclk);
        @(negedge aclk);
        check_value("s_ready", s_ready, 1'b1);  // up one cycle after release
        repeat (8) begin
            @(negedge aclk);
            check_value("m_valid", m_valid, 1'b0);  // idle until a row is sent
        end
        run_rows(6, "after reset", 6, KH_MIX, CH_RAND, 1'b0, 1'b1);
    endtask

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog expired before all windows arrived");
        $display("Checks failed");
        $finish;
    end

    initial begin
        lfsr_state = 16'd83;
        checks     = 0;
        errors     = 0;
        model_ch   = '0;
        model_pos  = 0;
        reset      = 1'b1;
        s_row      = '0;
        s_valid    = 1'b0;
        m_ready    = 1'b0;
        repeat (10) @(posedge aclk);
        reset <= 1'b0;

        run_rows(1, "kernel_h 3", ROWS_PER_TEST, KH_3, CH_RAND, 1'b0, 1'b1);
        run_rows(2, "kernel_h 1", ROWS_PER_TEST, KH_1, CH_RAND, 1'b0, 1'b1);
        run_rows(3, "m_ready stalls", ROWS_PER_TEST, KH_MIX, CH_RAND, 1'b1, 1'b0);
        run_rows(4, "tlast groups", ROWS_PER_TEST, KH_MIX, CH_CYCLE, 1'b1, 1'b1);
        run_rows(5, "kernel_h changes", ROWS_PER_TEST, KH_MIX, CH_RAND, 1'b1, 1'b1);
        reset_test();

        errors = errors + shift_buffer_top_inst.shift_buffer_assertions_inst.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
design/conv_types_pkg.sv
design/axis_stream_pkg.sv
design/skid_buffer.sv
design/beat_last_gen.sv
design/axis_shift_buffer.sv
design/shift_buffer_top.sv
dv/shift_buffer_assertions.sv
dv/shift_buffer_tb.sv

/* Bender.yml */
package:
  name: conv_row_shifter

sources:
  - include_dirs:
      - design
    files:
      - design/conv_types_pkg.sv
      - design/axis_stream_pkg.sv
      - design/skid_buffer.sv
      - design/beat_last_gen.sv
      - design/axis_shift_buffer.sv
      - design/shift_buffer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/shift_buffer_assertions.sv
      - dv/shift_buffer_tb.sv
